/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cache_to_mem
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src/arb_pkg.sv */
// requester tags; SRC_NONE is the reset value of the tag pipeline and means no owner
package arb_pkg;

    // who a memory read belongs to
    // SRC_NONE marks idle cycles and writes, which return nothing
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_I    = 2'd1,
        SRC_D    = 2'd2
    } req_src_t;

endpackage

/* src/cache_to_mem.sv */
// data_out is shared by both caches and is only meaningful while d_valid or i_valid is high
module cache_to_mem
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              d_enable,
    input  logic              d_write,
    input  logic [ADDR_W-1:0] d_addr,
    input  logic [DATA_W-1:0] d_data,
    input  logic              i_enable,
    input  logic [ADDR_W-1:0] i_addr,
    output logic              d_valid,
    output logic              i_valid,
    output logic [DATA_W-1:0] data_out
);

    // arbiter to memory request
    mem_req_if mem_req ();

    // memory read strobe back to the arbiter
    logic rvalid;

    mem_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .d_enable (d_enable),
        .d_write  (d_write),
        .d_addr   (d_addr),
        .d_data   (d_data),
        .i_enable (i_enable),
        .i_addr   (i_addr),
        .req      (mem_req),
        .rvalid   (rvalid),
        .d_valid  (d_valid),
        .i_valid  (i_valid)
    );

    // data goes to both caches and the valids pick the receiver
    memory4c main_mem (
        .clk    (clk),
        .rst    (rst),
        .req    (mem_req),
        .rdata  (data_out),
        .rvalid (rvalid)
    );

endmodule

/* src/mem_arbiter.sv */
// dcache wins every cycle; icache must keep at most one read outstanding, no back-pressure
module mem_arbiter
    import mem_pkg::*;
    import arb_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              d_enable,
    input  logic              d_write,
    input  logic [ADDR_W-1:0] d_addr,
    input  logic [DATA_W-1:0] d_data,
    input  logic              i_enable,
    input  logic [ADDR_W-1:0] i_addr,
    mem_req_if.arb            req,
    input  logic              rvalid,
    output logic              d_valid,
    output logic              i_valid
);

    // one-entry slot for an instruction read that lost to the dcache
    logic              pend_valid;
    logic [ADDR_W-1:0] pend_addr;

    // tag of the request currently on req, SRC_NONE for writes and idle
    req_src_t          issue_src;

    // tag pipeline, same depth as the memory read pipeline
    req_src_t          tag_q [MEM_LATENCY];
    req_src_t          ret_src;

    // icache has a read pending or in flight
    logic              i_busy;

    // request strobe, tag and pending flag
    always_ff @(posedge clk) begin
        if (rst) begin
            req.enable <= 1'b0;
            issue_src  <= SRC_NONE;
            pend_valid <= 1'b0;
        end else if (d_enable) begin
            req.enable <= 1'b1;
            // writes return nothing, so they carry no owner
            issue_src  <= d_write ? SRC_NONE : SRC_D;
            // instruction strobe in the same cycle parks here
            if (i_enable) begin
                pend_valid <= 1'b1;
            end
        end else if (pend_valid || i_enable) begin
            // parked request goes first, a fresh one cannot coexist with it
            req.enable <= 1'b1;
            issue_src  <= SRC_I;
            pend_valid <= 1'b0;
        end else begin
            req.enable <= 1'b0;
            issue_src  <= SRC_NONE;
        end
    end

    // request payload, qualified by req.enable downstream
    always_ff @(posedge clk) begin
        if (d_enable) begin
            req.wr    <= d_write;
            req.addr  <= d_addr;
            req.wdata <= d_data;
        end else begin
            // icache only reads
            req.wr   <= 1'b0;
            req.addr <= pend_valid ? pend_addr : i_addr;
        end
        // capture the losing instruction address
        if (d_enable && i_enable) begin
            pend_addr <= i_addr;
        end
    end

    // tag shift register
    // stage 0 loads at the same edge the memory samples the request
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                tag_q[i] <= SRC_NONE;
            end
        end else begin
            tag_q[0] <= issue_src;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                tag_q[i] <= tag_q[i-1];
            end
        end
    end

    // owner of the word leaving the memory this cycle
    assign ret_src = tag_q[MEM_LATENCY-1];

    // steer the memory valid to its requester
    assign d_valid = rvalid && (ret_src == SRC_D);
    assign i_valid = rvalid && (ret_src == SRC_I);

    // icache outstanding tracker
    // a new strobe in the return cycle keeps it busy
    always_ff @(posedge clk) begin
        if (rst) begin
            i_busy <= 1'b0;
        end else if (i_enable) begin
            i_busy <= 1'b1;
        end else if (i_valid) begin
            i_busy <= 1'b0;
        end
    end

    // usage rule: one icache read at a time
    a_i_one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        i_enable |-> (!i_busy || i_valid)
    ) else $error("mem_arbiter: i_enable while an icache read is outstanding");

    // every returning word must have an owner
    a_rvalid_tagged: assert property (
        @(posedge clk) disable iff (rst)
        rvalid |-> (ret_src != SRC_NONE)
    ) else $error("mem_arbiter: rvalid with no requester tag");

endmodule

/* src/mem_pkg.sv */
// word-addressed memory; byte address bit 0 must be zero, MEM_LATENCY must be at least 1
package mem_pkg;

    // byte address and data word widths seen by both caches
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // word index width
    // the index is addr[MEM_DEPTH_W:1], address bits above it are ignored
    localparam int MEM_DEPTH_W = 10;

    // number of words in the array, 1024 for a 10-bit index
    localparam int MEM_WORDS = 1 << MEM_DEPTH_W;

    // edges from the memory sampling a read to the edge that samples its data
    // the read path is pipelined, so this many reads may be in flight
    localparam int MEM_LATENCY = 4;

endpackage

/* src/mem_req_if.sv */
// single-cycle request strobe with no back-pressure; a request lives only while enable is high
interface mem_req_if
    import mem_pkg::*;
();

    // request strobe, one cycle per request
    logic              enable;
    // high for a write, low for a read
    logic              wr;
    // byte address, bit 0 zero
    logic [ADDR_W-1:0] addr;
    // write data, don't care on reads
    logic [DATA_W-1:0] wdata;

    // arbiter side drives every field
    modport arb (
        output enable,
        output wr,
        output addr,
        output wdata
    );

    // memory side only samples
    modport mem (
        input enable,
        input wr,
        input addr,
        input wdata
    );

endinterface

/* src/memory4c.sv */
// never-written words read back unknown; only the read valid bits are cleared by rst
module memory4c
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    mem_req_if.mem            req,
    output logic [DATA_W-1:0] rdata,
    output logic              rvalid
);

    // storage, one entry per 16-bit word
    logic [DATA_W-1:0]      mem_array [MEM_WORDS];

    // read pipeline, data and valid travel together
    logic [DATA_W-1:0]      rd_data_q [MEM_LATENCY];
    logic [MEM_LATENCY-1:0] rd_valid_q;

    // word index taken from the byte address
    logic [MEM_DEPTH_W-1:0] word_idx;
    logic                   rd_req;
    logic                   wr_req;

    // drop bit 0 and everything above the array depth
    assign word_idx = req.addr[MEM_DEPTH_W:1];

    assign rd_req = req.enable && !req.wr;
    assign wr_req = req.enable && req.wr;

    // write port
    // commits at the edge that samples the request, no valid returned
    always_ff @(posedge clk) begin
        if (wr_req) begin
            mem_array[word_idx] <= req.wdata;
        end
    end

    // read data stages
    // stage 0 grabs the array word at the sampling edge
    // later stages just shift, so back-to-back reads stay in order
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_data_q[0] <= mem_array[word_idx];
        end
        for (int i = 1; i < MEM_LATENCY; i++) begin
            rd_data_q[i] <= rd_data_q[i-1];
        end
    end

    // read valid stages, one bit per read in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q[0] <= rd_req;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                rd_valid_q[i] <= rd_valid_q[i-1];
            end
        end
    end

    // last stage is the return port
    // rvalid is high for exactly one cycle per read
    assign rdata  = rd_data_q[MEM_LATENCY-1];
    assign rvalid = rd_valid_q[MEM_LATENCY-1];

    // requests must be word aligned
    a_addr_aligned: assert property (
        @(posedge clk) disable iff (rst)
        req.enable |-> !req.addr[0]
    ) else $error("memory4c: unaligned address %h", req.addr);

endmodule

/* tb.f */
src/mem_pkg.sv
src/arb_pkg.sv
src/mem_req_if.sv
src/memory4c.sv
src/mem_arbiter.sv
src/cache_to_mem.sv
tests/tb_cache_to_mem.sv

/* tests/tb_cache_to_mem.sv */
// reads touch only written words, addresses stay word aligned, icache keeps one read outstanding
module tb_cache_to_mem
    import mem_pkg::*;
();

    // length of the random traffic test
    localparam int RAND_CYCLES    = 600;
    // directed tests plus random traffic need about 1200 cycles, the rest is slack
    localparam int TIMEOUT_CYCLES = 2000;

    logic              clk;
    logic              rst;
    logic              d_enable;
    logic              d_write;
    logic [ADDR_W-1:0] d_addr;
    logic [DATA_W-1:0] d_data;
    logic              i_enable;
    logic [ADDR_W-1:0] i_addr;
    logic              d_valid;
    logic              i_valid;
    logic [DATA_W-1:0] data_out;

    // rising edges seen so far
    int cycle_count = 0;

    // reference memory, keyed by word index
    logic [DATA_W-1:0] model_mem [int];
    // word indices written at least once
    int                written [$];

    // expected returns, due cycle and data side by side
    int                d_due [$];
    logic [DATA_W-1:0] d_exp [$];
    int                i_due [$];
    logic [DATA_W-1:0] i_exp [$];

    // replayed pending slot of the arbiter
    logic              model_pend = 1'b0;
    logic [ADDR_W-1:0] model_pend_addr;
    // icache read driven and not yet returned
    logic              i_outstanding = 1'b0;

    // bookkeeping
    string test_name;
    int    test_errors;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    cache_to_mem u_cache_to_mem (
        .clk      (clk),
        .rst      (rst),
        .d_enable (d_enable),
        .d_write  (d_write),
        .d_addr   (d_addr),
        .d_data   (d_data),
        .i_enable (i_enable),
        .i_addr   (i_addr),
        .d_valid  (d_valid),
        .i_valid  (i_valid),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // watchdog
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // word index the memory uses, upper bits dropped
    function automatic int word_of(input logic [ADDR_W-1:0] a);
        return int'(a[MEM_DEPTH_W:1]);
    endfunction

    // random upper bits on purpose, the memory must ignore them
    function automatic logic [ADDR_W-1:0] make_addr(input int idx);
        logic [ADDR_W-1:0] a;
        a = ADDR_W'($urandom);
        a[MEM_DEPTH_W:1] = MEM_DEPTH_W'(idx);
        a[0] = 1'b0;
        return a;
    endfunction

    function automatic int pick_written();
        return written[$urandom_range(written.size() - 1, 0)];
    endfunction

    // replay of the priority rule, request issued at the next edge
    task automatic replay_issue(input logic de, input logic dw, input logic [ADDR_W-1:0] da,
                                input logic [DATA_W-1:0] dd, input logic ie,
                                input logic [ADDR_W-1:0] ia);
        int issue_cyc;
        int idx;
        issue_cyc = cycle_count + 1;
        if (ie) begin
            i_outstanding = 1'b1;
        end
        if (de) begin
            idx = word_of(da);
            if (dw) begin
                if (!model_mem.exists(idx)) begin
                    written.push_back(idx);
                end
                model_mem[idx] = dd;
            end else begin
                d_due.push_back(issue_cyc + MEM_LATENCY);
                d_exp.push_back(model_mem[idx]);
            end
            // losing icache strobe parks
            if (ie) begin
                model_pend      = 1'b1;
                model_pend_addr = ia;
            end
        end else if (model_pend || ie) begin
            idx = word_of(model_pend ? model_pend_addr : ia);
            i_due.push_back(issue_cyc + MEM_LATENCY);
            i_exp.push_back(model_mem[idx]);
            model_pend = 1'b0;
        end
    endtask

    // compare both valids and the shared data against the queues
    task automatic check_outputs();
        logic exp_d;
        logic exp_i;
        exp_d = (d_due.size() > 0) && (d_due[0] == cycle_count);
        exp_i = (i_due.size() > 0) && (i_due[0] == cycle_count);
        checks += 2;
        assert (d_valid === exp_d) else begin
            errors++;
            test_errors++;
            if (exp_d) begin
                $display("%s: d_valid missing at cycle %0d", test_name, cycle_count);
            end else begin
                $display("%s: unexpected d_valid at cycle %0d", test_name, cycle_count);
            end
        end
        assert (i_valid === exp_i) else begin
            errors++;
            test_errors++;
            if (exp_i) begin
                $display("%s: i_valid missing at cycle %0d", test_name, cycle_count);
            end else begin
                $display("%s: unexpected i_valid at cycle %0d", test_name, cycle_count);
            end
        end
        if (exp_d) begin
            checks++;
            assert (data_out === d_exp[0]) else begin
                errors++;
                test_errors++;
                $display("ERR %s d read exp %h got %h", test_name, d_exp[0], data_out);
            end
            void'(d_due.pop_front());
            void'(d_exp.pop_front());
        end
        if (exp_i) begin
            checks++;
            assert (data_out === i_exp[0]) else begin
                errors++;
                test_errors++;
                $display("ERR %s i read exp %h got %h", test_name, i_exp[0], data_out);
            end
            void'(i_due.pop_front());
            void'(i_exp.pop_front());
            i_outstanding = 1'b0;
        end
    endtask

    // one clock: check just after the edge, drive 2 units after it
    task automatic run_cycle(input logic de, input logic dw, input logic [ADDR_W-1:0] da,
                             input logic [DATA_W-1:0] dd, input logic ie,
                             input logic [ADDR_W-1:0] ia);
        @(posedge clk);
        #1;
        check_outputs();
        #1;
        d_enable = de;
        d_write  = dw;
        d_addr   = da;
        d_data   = dd;
        i_enable = ie;
        i_addr   = ia;
        replay_issue(de, dw, da, dd, ie, ia);
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    // dcache read or write, with an optional icache strobe alongside
    task automatic random_d_cycle(input logic ie, input logic [ADDR_W-1:0] ia);
        logic wr;
        int   idx;
        wr = (written.size() == 0) || ($urandom % 2 == 1);
        if (written.size() == 0 || (wr && $urandom % 4 == 0)) begin
            idx = int'($urandom_range(MEM_WORDS - 1, 0));
        end else begin
            idx = pick_written();
        end
        run_cycle(1'b1, wr, make_addr(idx), DATA_W'($urandom), ie, ia);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // drain everything in flight, then watch a few quiet cycles for strays
    task automatic end_test();
        while (d_due.size() != 0 || i_due.size() != 0 || model_pend) begin
            idle_cycle();
        end
        repeat (MEM_LATENCY + 2) idle_cycle();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        int   idx;
        logic wr;
        logic ie;
        logic [ADDR_W-1:0] ia;
        void'($urandom(97));
        rst      = 1'b1;
        d_enable = 1'b0;
        d_write  = 1'b0;
        d_addr   = '0;
        d_data   = '0;
        i_enable = 1'b0;
        i_addr   = '0;

        // valids stay low through reset and the quiet cycles after
        begin_test("reset");
        repeat (4) idle_cycle();
        rst = 1'b0;
        repeat (8) idle_cycle();
        end_test();

        begin_test("write_read");
        repeat (24) begin
            run_cycle(1'b1, 1'b1, make_addr(int'($urandom_range(MEM_WORDS - 1, 0))),
                      DATA_W'($urandom), 1'b0, '0);
        end
        for (int n = 0; n < written.size(); n++) begin
            run_cycle(1'b0, 1'b0, make_addr(written[n]), '0, 1'b0, '0);
            idle_cycle();
        end
        end_test();

        // back-to-back strobes, one return per cycle
        begin_test("pipelined");
        repeat (32) run_cycle(1'b1, 1'b0, make_addr(pick_written()), '0, 1'b0, '0);
        end_test();

        begin_test("instr");
        repeat (24) begin
            run_cycle(1'b0, 1'b0, '0, '0, 1'b1, make_addr(pick_written()));
            while (i_outstanding) idle_cycle();
        end
        end_test();

        // same-cycle strobes, a write to the fetched word checks issue order
        begin_test("collision");
        repeat (16) begin
            idx = pick_written();
            wr  = ($urandom % 2 == 1);
            run_cycle(1'b1, wr, make_addr(wr ? idx : pick_written()), DATA_W'($urandom),
                      1'b1, make_addr(idx));
            repeat ($urandom_range(3, 0)) random_d_cycle(1'b0, '0);
            while (i_outstanding) idle_cycle();
        end
        end_test();

        begin_test("random");
        for (int n = 0; n < RAND_CYCLES; n++) begin
            ie = !i_outstanding && ($urandom % 100 < 30);
            ia = ie ? make_addr(pick_written()) : '0;
            if ($urandom % 100 < 55) begin
                random_d_cycle(ie, ia);
            end else begin
                run_cycle(1'b0, 1'b0, '0, '0, ie, ia);
            end
        end
        end_test();

        $display("tests %0d run, %0d failed; checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
